/* logic/video_pkg.sv */
/*
 * raster and output side definitions for the scroll layer
 *  - raster counter width
 *  - scroll register bundle (pages, hscr, vscr)
 *  - output pixel layout
 *  - horizontal pixel lead of the fetch pipeline
 */

package video_pkg;

    // hdump / vdump width, 512 x 512 raster space
    localparam int raster_w = 9;

    // added to the scrolled h position so the fetch runs two tiles ahead
    // of the beam, the tile pipeline eats exactly 16 pixels
    localparam int unsigned pixel_lead = 16;

    // memory mapped scroll registers as seen by the layer
    typedef struct packed {
        logic [15:0] pages;     // four 3-bit page numbers, one per nibble
        logic [15:0] hscr;      // only 8:0 used here
        logic [15:0] vscr;      // only 7:0 used here
    } scroll_regs_t;

    // 1 priority + 7 palette + 3 colour = 11 bits
    typedef struct packed {
        logic       prio;
        logic [6:0] palette;
        logic [2:0] colour;
    } pxl_t;

endpackage

/* logic/tile_pkg.sv */
/*
 * tile memory side definitions
 *  - map and graphics address widths
 *  - map word and graphics word types
 *  - page quadrant enum
 *  - decoded tile entry and its field extractors
 */

package tile_pkg;

    localparam int map_addr_w = 14;     // 3 page bits + 11 scan bits
    localparam int gfx_addr_w = 17;     // bank + code + row + half select

    typedef logic [15:0] map_word_t;
    typedef logic [31:0] gfx_word_t;    // planes in 23:0, top byte unused

    // index is {vov, ~hov}, picks one nibble of the pages register
    typedef enum logic [1:0] {
        q_00 = 2'b00,   // pages[2:0]
        q_01 = 2'b01,   // pages[6:4]
        q_10 = 2'b10,   // pages[10:8]
        q_11 = 2'b11    // pages[14:12]
    } quadrant_e;

    // fields overlap inside the map word, see extractors below
    typedef struct packed {
        logic        bank;
        logic [11:0] code;
        logic [7:0]  attr;
    } tile_info_t;

    function automatic logic tile_bank(input map_word_t w);
        return w[13];
    endfunction

    function automatic logic [11:0] tile_code(input map_word_t w);
        return w[11:0];
    endfunction

    // attr shares bits 11:5 with the code
    function automatic logic [7:0] tile_attr(input map_word_t w);
        return w[12:5];
    endfunction

    function automatic tile_info_t to_tile_info(input map_word_t w);
        tile_info_t t;
        t.bank = tile_bank(w);
        t.code = tile_code(w);
        t.attr = tile_attr(w);
        return t;
    endfunction

endpackage

/* logic/scroll_addr_gen.sv */
/*
 * scroll address generator
 * applies hscr / vscr to the raster position, selects the map page
 * by quadrant and registers the map address at each 8 pixel boundary
 * together with a one cycle tile_load strobe
 */

module scroll_addr_gen (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pxl_cen,
    input  video_pkg::scroll_regs_t           regs,
    input  logic [video_pkg::raster_w-1:0]    hdump,
    input  logic [video_pkg::raster_w-1:0]    vdump,
    output logic [tile_pkg::map_addr_w-1:0]   map_addr,
    output logic [2:0]                        fine_row,   // row inside the tile
    output logic                              tile_load
);

    logic [8:0]          hpos;
    logic                hov;           // horizontal overflow past 512
    logic [7:0]          vpos;
    logic                vov;           // vertical overflow past 256
    logic [10:0]         scan_addr;     // 32 rows x 64 columns of tiles
    logic [2:0]          page;
    tile_pkg::quadrant_e quad;
    logic                boundary;

    always_comb begin
        // ~hscr counts the scroll backwards, lead puts fetch ahead of beam
        {hov, hpos} = {1'b0, hdump} + {1'b0, ~regs.hscr[8:0]}
                    + 10'(video_pkg::pixel_lead);
        // vdump bit 8 folds into the overflow bit
        {vov, vpos} = vdump + {1'b0, regs.vscr[7:0]};
        scan_addr   = {vpos[7:3], hpos[8:3]};
        quad        = tile_pkg::quadrant_e'({vov, ~hov});
        case (quad)
            tile_pkg::q_11: page = regs.pages[14:12];
            tile_pkg::q_10: page = regs.pages[10:8];
            tile_pkg::q_01: page = regs.pages[6:4];
            default:        page = regs.pages[2:0];     // q_00
        endcase
    end

    assign fine_row = vpos[2:0];
    assign boundary = pxl_cen && (hpos[2:0] == 3'd0);  // first pixel of a tile

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            map_addr  <= '0;
            tile_load <= 1'b0;
        end else begin
            tile_load <= boundary;      // map data valid while this is high
            if (boundary) begin
                map_addr <= {page, scan_addr};
            end
        end
    end

endmodule

/* logic/tile_latch.sv */
/*
 * tile latch
 * captures the map entry on tile_load, then hands code and attribute
 * down one tile later so graphics fetch and attribute stay paired
 * graphics address is formed combinationally from the held entry
 */

module tile_latch (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              tile_load,
    input  tile_pkg::map_word_t               map_data,
    input  logic [2:0]                        fine_row,
    output logic [tile_pkg::gfx_addr_w-1:0]   gfx_addr,
    output logic [7:0]                        attr_out
);

    // entry just read from the map, address issued at this boundary
    tile_pkg::tile_info_t cur;

    // entry from the previous boundary, the one being drawn next
    logic        row_bank;
    logic [11:0] row_code;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            cur      <= '0;
            row_bank <= 1'b0;
            row_code <= '0;
            attr_out <= '0;
        end else if (tile_load) begin
            cur      <= tile_pkg::to_tile_info(map_data);
            row_bank <= cur.bank;       // shift the old entry one stage on
            row_code <= cur.code;
            attr_out <= cur.attr;       // travels with the planes it colours
        end
    end

    // bank, code, row within tile, low bit zero picks the 32 bit word
    assign gfx_addr = {row_bank, row_code, fine_row, 1'b0};

endmodule

/* logic/pixel_shifter.sv */
/*
 * pixel shifter
 * three 8 bit plane shift registers and the tile attribute
 * loaded on tile_load, shifted left once per pixel
 * pixel = attribute + top bit of each plane
 */

module pixel_shifter (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pxl_cen,
    input  logic                  tile_load,
    input  tile_pkg::gfx_word_t   gfx_data,
    input  logic [7:0]            attr,
    output video_pkg::pxl_t       pxl
);

    logic [2:0][7:0] planes;    // [2] = gfx 23:16 ... [0] = gfx 7:0
    logic [7:0]      attr_q;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            planes <= '0;
            attr_q <= '0;
        end else if (tile_load) begin
            planes <= gfx_data[23:0];   // top byte of the word not used
            attr_q <= attr;
        end else if (pxl_cen) begin
            // each plane shifts alone, no bits cross plane borders
            for (int p = 0; p < 3; p++) begin
                planes[p] <= {planes[p][6:0], 1'b0};
            end
        end
    end

    always_comb begin
        pxl.prio    = attr_q[7];
        pxl.palette = attr_q[6:0];
        pxl.colour  = {planes[2][7], planes[1][7], planes[0][7]};
    end

endmodule

/* logic/scroll_layer.sv */
/*
 * scroll tile layer top
 * address generator -> tile latch -> pixel shifter
 * map and graphics memories live outside and answer in the same cycle
 */

module scroll_layer (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              pxl_cen,    // one clock pulse per pixel
    input  video_pkg::scroll_regs_t           regs,
    input  logic [video_pkg::raster_w-1:0]    hdump,
    input  logic [video_pkg::raster_w-1:0]    vdump,
    output logic [tile_pkg::map_addr_w-1:0]   map_addr,
    input  tile_pkg::map_word_t               map_data,
    output logic [tile_pkg::gfx_addr_w-1:0]   gfx_addr,
    input  tile_pkg::gfx_word_t               gfx_data,
    output video_pkg::pxl_t                   pxl
);

    logic [2:0] fine_row;
    logic       tile_load;      // one clock after each boundary pxl_cen
    logic [7:0] tile_attr;

    scroll_addr_gen u_addr_gen (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .regs      (regs),
        .hdump     (hdump),
        .vdump     (vdump),
        .map_addr  (map_addr),
        .fine_row  (fine_row),
        .tile_load (tile_load)
    );

    tile_latch u_latch (
        .clk       (clk),
        .rst       (rst),
        .tile_load (tile_load),
        .map_data  (map_data),
        .fine_row  (fine_row),
        .gfx_addr  (gfx_addr),
        .attr_out  (tile_attr)
    );

    pixel_shifter u_shifter (
        .clk       (clk),
        .rst       (rst),
        .pxl_cen   (pxl_cen),
        .tile_load (tile_load),
        .gfx_data  (gfx_data),
        .attr      (tile_attr),
        .pxl       (pxl)
    );

endmodule

/* test/scroll_mem_model.sv */
/*
 * memory models for the scroll layer testbench
 *  - map memory, 16 bit words
 *  - graphics memory, 32 bit words
 * both answer combinationally, contents drawn from $urandom
 */

module scroll_mem_model (
    input  logic [tile_pkg::map_addr_w-1:0]   map_addr,
    output tile_pkg::map_word_t               map_data,
    input  logic [tile_pkg::gfx_addr_w-1:0]   gfx_addr,
    output tile_pkg::gfx_word_t               gfx_data
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int map_words = 1 << tile_pkg::map_addr_w;  // 8 pages of 32 x 64 tiles
    localparam int gfx_words = 1 << tile_pkg::gfx_addr_w;

    tile_pkg::map_word_t map_mem [map_words];
    tile_pkg::gfx_word_t gfx_mem [gfx_words];

    // runs in the caller's process, after the seed is set
    task automatic fill_random();
        for (int a = 0; a < map_words; a++) begin
            map_mem[a] = tile_pkg::map_word_t'($urandom());
        end
        // top byte random as well, the layer must ignore it
        for (int a = 0; a < gfx_words; a++) begin
            gfx_mem[a] = tile_pkg::gfx_word_t'($urandom());
        end
    endtask

    // same cycle answer, no wait states
    assign map_data = map_mem[map_addr];
    assign gfx_data = gfx_mem[gfx_addr];

endmodule

/* test/scroll_layer_tb.sv */
/*
 * testbench for the scroll tile layer
 *  - clock, reset and random map / graphics contents
 *  - table of scroll settings walked one pixel at a time
 *  - reference of the fetch, latch and shift pipeline
 *  - typed compare tasks and a cycle limit
 */

module scroll_layer_tb;

    timeunit 1ns;
    timeprecision 1ps;

    typedef logic [tile_pkg::map_addr_w-1:0] map_addr_t;
    typedef logic [tile_pkg::gfx_addr_w-1:0] gfx_addr_t;

    // numeric part of a table row, names kept alongside
    typedef struct packed {
        logic [15:0] pages;
        logic [15:0] hscr;
        logic [15:0] vscr;
        logic [8:0]  vdump;
        logic [8:0]  hstart;    // first hdump of the row
        logic [15:0] count;     // pixels to run
    } test_row_t;

    localparam int n_tests          = 5;
    localparam int reset_cycles     = 10;
    localparam int clocks_per_pixel = 4;    // pxl_cen one clock in four
    localparam int margin           = 200;

    logic                    clk;
    logic                    rst;
    logic                    pxl_cen;
    video_pkg::scroll_regs_t regs;
    logic [8:0]              hdump;
    logic [8:0]              vdump;
    map_addr_t               map_addr;
    tile_pkg::map_word_t     map_data;
    gfx_addr_t               gfx_addr;
    tile_pkg::gfx_word_t     gfx_data;
    video_pkg::pxl_t         pxl;

    test_row_t tests [n_tests];
    string     test_name [n_tests];
    int        cycle_count = 0;
    int        cycle_limit = 0;

    // reference pipeline state
    map_addr_t           exp_map_addr;
    tile_pkg::map_word_t cur_word;      // fetched at the last boundary
    tile_pkg::map_word_t row_word;      // one boundary older, addresses gfx
    logic [7:0]          exp_planes [3];
    logic [7:0]          exp_attr;

    scroll_layer dut0 (
        .clk      (clk),
        .rst      (rst),
        .pxl_cen  (pxl_cen),
        .regs     (regs),
        .hdump    (hdump),
        .vdump    (vdump),
        .map_addr (map_addr),
        .map_data (map_data),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data),
        .pxl      (pxl)
    );

    scroll_mem_model mem0 (
        .map_addr (map_addr),
        .map_data (map_data),
        .gfx_addr (gfx_addr),
        .gfx_data (gfx_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("the run hung, %0d cycles passed without finishing", cycle_count);
            $display("*** TEST FAILED ***");
            $fatal(1, "cycle limit reached");
        end
    end

    task automatic check_map_addr(input string name, input map_addr_t expected,
                                  input map_addr_t actual);
        if (actual !== expected) begin
            $display("FAILED %s map_addr expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "map_addr mismatch");
        end
    endtask

    task automatic check_gfx_addr(input string name, input gfx_addr_t expected,
                                  input gfx_addr_t actual);
        if (actual !== expected) begin
            $display("FAILED %s gfx_addr expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "gfx_addr mismatch");
        end
    endtask

    task automatic check_pxl(input string name, input video_pkg::pxl_t expected,
                             input video_pkg::pxl_t actual);
        if (actual !== expected) begin
            $display("FAILED %s pxl expected %h actual %h", name, expected, actual);
            $display("*** TEST FAILED ***");
            $fatal(1, "pxl mismatch");
        end
    endtask

    // columns: pages, hscr, vscr, vdump, hstart, count
    task automatic load_table();
        tests[0] = '{16'h4321, 16'h0000, 16'h0000, 9'd40,  9'd0,   16'd64};
        tests[1] = '{16'h4321, 16'h0000, 16'h0000, 9'd100, 9'd480, 16'd40};  // hdump wraps
        tests[2] = '{16'h7531, 16'h0123, 16'h00f0, 9'd20,  9'd200, 16'd80};  // q_11 then q_10
        tests[3] = '{16'h6152, 16'h01a7, 16'h0033, 9'd60,  9'd380, 16'd96};  // q_01 then q_00
        tests[4] = '{16'h2706, 16'h0005, 16'h0010, 9'd250, 9'd0,   16'd48};  // past 256
        test_name[0] = "zero_scroll";
        test_name[1] = "zero_scroll_hwrap";
        test_name[2] = "scroll_upper_quads";
        test_name[3] = "scroll_lower_quads";
        test_name[4] = "vertical_wrap";
    endtask

    // bank, code, tile row, low half select
    function automatic gfx_addr_t row_gfx_addr(input tile_pkg::map_word_t w,
                                               input logic [2:0] fine);
        return {w[13], w[11:0], fine, 1'b0};
    endfunction

    function automatic video_pkg::pxl_t expected_pxl();
        video_pkg::pxl_t p;
        p.prio    = exp_attr[7];
        p.palette = exp_attr[6:0];
        p.colour  = {exp_planes[2][7], exp_planes[1][7], exp_planes[0][7]};
        return p;
    endfunction

    // one pxl_cen period, four clocks, inputs change on falling edges
    task automatic run_pixel(input int t, input logic [8:0] h);
        int                  hsum;
        int                  vsum;
        int                  hov;
        int                  vov;
        int                  page;
        logic                boundary;
        logic [2:0]          fine;
        map_addr_t           next_addr;
        tile_pkg::gfx_word_t gword;
        @(negedge clk);
        pxl_cen    = 1'b1;
        hdump      = h;
        vdump      = tests[t].vdump;
        regs.pages = tests[t].pages;
        regs.hscr  = tests[t].hscr;
        regs.vscr  = tests[t].vscr;
        // hscr enters inverted, lead keeps fetch two tiles ahead
        hsum = int'(h) + (511 - int'(tests[t].hscr[8:0])) + int'(video_pkg::pixel_lead);
        vsum = int'(tests[t].vdump) + int'(tests[t].vscr[7:0]);
        hov  = (hsum / 512) % 2;
        vov  = (vsum / 256) % 2;
        page = int'(tests[t].pages >> (4 * (vov * 2 + (1 - hov)))) % 8;  // nibble by quadrant
        fine = 3'((vsum % 256) % 8);
        next_addr = map_addr_t'(page * 2048 + ((vsum % 256) / 8) * 64 + (hsum % 512) / 8);
        boundary  = ((hsum % 512) % 8) == 0;
        @(negedge clk);
        pxl_cen = 1'b0;
        for (int p = 0; p < 3; p++) begin
            exp_planes[p] = {exp_planes[p][6:0], 1'b0};     // shift on the pxl_cen edge
        end
        if (boundary) begin
            exp_map_addr = next_addr;
        end
        check_map_addr(test_name[t], exp_map_addr, map_addr);
        check_gfx_addr(test_name[t], row_gfx_addr(row_word, fine), gfx_addr);
        check_pxl(test_name[t], expected_pxl(), pxl);
        if (boundary) begin
            // planes and attribute of the entry two boundaries back
            gword         = mem0.gfx_mem[row_gfx_addr(row_word, fine)];
            exp_planes[2] = gword[23:16];
            exp_planes[1] = gword[15:8];
            exp_planes[0] = gword[7:0];
            exp_attr      = row_word[12:5];
            row_word      = cur_word;
            cur_word      = mem0.map_mem[exp_map_addr];
        end
        @(negedge clk);
        check_pxl(test_name[t], expected_pxl(), pxl);   // after the tile_load edge
        @(negedge clk);
    endtask

    initial begin
        int total;
        rst          = 1'b1;
        pxl_cen      = 1'b0;
        regs         = '0;
        hdump        = '0;
        vdump        = '0;
        exp_map_addr = '0;
        cur_word     = '0;
        row_word     = '0;
        exp_attr     = '0;
        for (int p = 0; p < 3; p++) begin
            exp_planes[p] = '0;
        end
        load_table();
        total = 0;
        for (int t = 0; t < n_tests; t++) begin
            total += int'(tests[t].count);
        end
        cycle_limit = total * clocks_per_pixel + reset_cycles + margin;
        void'($urandom(81));
        mem0.fill_random();
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // nothing fetched yet
        check_map_addr("reset", '0, map_addr);
        check_gfx_addr("reset", '0, gfx_addr);
        check_pxl("reset", '0, pxl);
        for (int t = 0; t < n_tests; t++) begin
            for (int j = 0; j < int'(tests[t].count); j++) begin
                run_pixel(t, 9'(int'(tests[t].hstart) + j));   // hdump wraps at 512
            end
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog.f */
logic/video_pkg.sv
logic/tile_pkg.sv
logic/scroll_addr_gen.sv
logic/tile_latch.sv
logic/pixel_shifter.sv
logic/scroll_layer.sv
test/scroll_mem_model.sv
test/scroll_layer_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the scroll layer testbench with Verilator and run it
# exit status is nonzero when the build fails or the testbench stops on $fatal
cd "$(dirname "$0")" || exit 1
verilator --binary --timescale 1ns/1ps --top-module scroll_layer_tb \
    -f verilog.f -Mdir obj_dir \
    && ./obj_dir/Vscroll_layer_tb \
    || { echo "simulation did not pass"; exit 1; }
